/* load_queue.sv */
// load queue and ordering check
`timescale 1ns/100ps
`default_nettype none

module load_queue #(
  parameter int DEPTH = 8,
  localparam int IDX_W = $clog2(DEPTH)
) (
  input  logic               clk,
  input  logic               rst,
  input  logic               ld_en,
  input  logic [IDX_W-1:0]   ld_idx,
  input  lsq_pkg::lsq_addr_u ld_addr,
  input  logic               st_en,
  input  logic [IDX_W-1:0]   st_idx,
  input  lsq_pkg::lsq_addr_u st_addr,
  input  logic [IDX_W-1:0]   head_idx,
  input  logic [IDX_W-1:0]   tail_idx,
  input  logic               flush,
  output logic [DEPTH-1:0]   ld_done,
  output logic [DEPTH-1:0]   ld_confl
);
  import lsq_pkg::*;

  logic [WORD_W-1:0] ld_word [DEPTH];
  logic [IDX_W-1:0]  head_q;
  logic [IDX_W-1:0]  st_rel;
  logic [IDX_W-1:0]  tail_rel;
  logic [DEPTH-1:0]  exec_set;
  logic [DEPTH-1:0]  free_clr;
  logic [DEPTH-1:0]  confl_set;

  // positions counted from the head, so the wrap drops out
  assign st_rel   = st_idx - head_idx;
  assign tail_rel = tail_idx - head_idx;

  assign exec_set = ld_en ? (DEPTH'(1) << ld_idx) : '0;
  // slot the head just left
  assign free_clr = (head_q != head_idx) ? (DEPTH'(1) << head_q) : '0;

  always_comb begin
    logic [IDX_W-1:0]  slot_rel;
    logic [WORD_W-1:0] slot_word;
    logic              slot_exec;
    for (int i = 0; i < DEPTH; i++) begin
      slot_rel  = IDX_W'(i) - head_idx;
      slot_exec = ld_done[i] || exec_set[i];
      slot_word = exec_set[i] ? ld_addr.flat[ADDR_W-1:OFF_W] : ld_word[i];
      // tail_rel of zero with live loads means every slot is in use
      confl_set[i] = st_en && slot_exec
                     && (slot_word == st_addr.flat[ADDR_W-1:OFF_W])
                     && (slot_rel > st_rel)
                     && ((tail_rel == '0) || (slot_rel < tail_rel));
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      ld_done  <= '0;
      ld_confl <= '0;
      head_q   <= '0;
    end else begin
      head_q <= head_idx;
      if (flush) begin
        ld_done  <= '0;
        ld_confl <= '0;
      end else begin
        ld_done  <= (ld_done & ~free_clr) | exec_set;
        ld_confl <= (ld_confl & ~free_clr) | confl_set;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (ld_en) begin
      ld_word[ld_idx] <= ld_addr.flat[ADDR_W-1:OFF_W];
    end
  end

endmodule

`default_nettype wire

/* lsq_pkg.sv */
// load/store queue shared definitions
`default_nettype none

package lsq_pkg;

  // address and data widths
  localparam int ADDR_W = 16;
  localparam int DATA_W = 32;
  localparam int BEN_W  = 4;
  localparam int OFF_W  = 2;
  localparam int WORD_W = ADDR_W - OFF_W;

  // access size codes
  localparam int SZ_W = 2;
  localparam logic [SZ_W-1:0] SZ_BYTE = 2'd0;
  localparam logic [SZ_W-1:0] SZ_HALF = 2'd1;
  localparam logic [SZ_W-1:0] SZ_WORD = 2'd2;

  // word number and byte offset within the word
  typedef struct packed {
    logic [WORD_W-1:0] word;
    logic [OFF_W-1:0]  off;
  } lsq_addr_f_t;

  // one byte address, seen flat or split into fields
  typedef union packed {
    logic [ADDR_W-1:0] flat;
    lsq_addr_f_t       f;
  } lsq_addr_u;

endpackage

`default_nettype wire

/* lsq_tb.sv */
// load/store queue testbench
`timescale 1ns/100ps
`default_nettype none

module lsq_tb;
  import lsq_pkg::*;

  localparam int DEPTH         = 8;
  localparam int IDX_W         = 3;
  localparam int CACHE_CREDITS = 2;
  localparam int N_ROUNDS      = 6;
  localparam int ROUND_OPS     = 6;
  localparam int N_CONFL       = 3;
  localparam int BURST_MAX     = 20;
  localparam int N_OPS = N_ROUNDS * ROUND_OPS + N_CONFL * 4 + BURST_MAX;
  localparam int LIMIT = 40 * N_OPS + 200;

  logic              clk = 1'b0;
  logic              rst = 1'b1;
  logic              alloc_en = 1'b0;
  logic              alloc_is_store = 1'b0;
  logic              ld_en = 1'b0;
  logic [IDX_W-1:0]  ld_idx = '0;
  lsq_addr_u         ld_addr = '0;
  logic              st_en = 1'b0;
  logic [IDX_W-1:0]  st_idx = '0;
  lsq_addr_u         st_addr = '0;
  logic [SZ_W-1:0]   st_size = '0;
  logic [DATA_W-1:0] st_data = '0;
  logic              wr_credit = 1'b0;
  logic [IDX_W-1:0]  alloc_idx;
  logic              full;
  logic              ret_en;
  logic [IDX_W-1:0]  ret_idx;
  logic              ret_confl;
  logic              wr_valid;
  logic [WORD_W-1:0] wr_word;
  logic [BEN_W-1:0]  wr_ben;
  logic [DATA_W-1:0] wr_data;

  // reference model state
  logic [IDX_W-1:0]  tail_ref = '0;
  logic [IDX_W-1:0]  exp_idx [$];
  logic              exp_confl [$];
  logic              exp_st [$];
  logic [WORD_W-1:0] exp_word [$];
  logic [BEN_W-1:0]  exp_ben [$];
  logic [DATA_W-1:0] exp_data [$];
  logic [WORD_W-1:0] slot_word [DEPTH];
  logic [BEN_W-1:0]  slot_ben [DEPTH];
  logic [DATA_W-1:0] slot_data [DEPTH];
  int                due_q [$];
  logic [31:0]       rng = 32'hebb834eb;
  int                cycle = 0;
  int                outstanding = 0;
  int                err_ret = 0;
  int                err_wr = 0;
  int                err_misc = 0;
  logic              hold_credits = 1'b0;

  lsq_top #(.DEPTH(DEPTH), .DRAIN_DEPTH(4), .CACHE_CREDITS(CACHE_CREDITS)) dut_i (.*);

  initial begin
    forever #4 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle++;
    if (cycle > LIMIT) begin
      $display("timeout after %0d cycles, queue did not drain", cycle);
      $display("Simulation failed");
      $finish;
    end
  end

  function automatic logic [31:0] xorshift32();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  task automatic step();
    @(posedge clk);
    #1;
  endtask

  // slots that get flushed are allocated but never expected to retire
  task automatic alloc_op(input logic is_st, input logic confl, input logic retires);
    while (full) step();
    assert (alloc_idx == tail_ref) else begin
      err_misc++;
      $display("error alloc_idx expected %h actual %h", tail_ref, alloc_idx);
    end
    alloc_en = 1'b1;
    alloc_is_store = is_st;
    if (retires) begin
      exp_idx.push_back(tail_ref);
      exp_confl.push_back(confl);
      exp_st.push_back(is_st);
    end
    tail_ref = tail_ref + 3'd1;
    step();
    alloc_en = 1'b0;
  endtask

  task automatic exec_load(input logic [IDX_W-1:0] idx, input logic [ADDR_W-1:0] addr);
    ld_en = 1'b1;
    ld_idx = idx;
    ld_addr.flat = addr;
    step();
    ld_en = 1'b0;
  endtask

  // expected cache write from size and byte offset
  task automatic exec_store(input logic [IDX_W-1:0] idx, input logic [ADDR_W-1:0] addr,
                            input logic [SZ_W-1:0] size, input logic [DATA_W-1:0] data);
    int          nbytes;
    int          off;
    logic [31:0] lanes;
    logic [3:0]  mask;
    nbytes = (size == SZ_BYTE) ? 1 : (size == SZ_HALF) ? 2 : 4;
    off = int'(addr[1:0]);
    lanes = '0;
    mask = '0;
    for (int b = 0; b < 4; b++) begin
      if (b < nbytes && b + off < 4) begin
        lanes[8*(b+off) +: 8] = data[8*b +: 8];
        mask[b+off] = 1'b1;
      end
    end
    slot_word[idx] = addr[ADDR_W-1:2];
    slot_ben[idx] = mask;
    slot_data[idx] = lanes;
    st_en = 1'b1;
    st_idx = idx;
    st_addr.flat = addr;
    st_size = size;
    st_data = data;
    step();
    st_en = 1'b0;
  endtask

  task automatic rand_store(input logic [IDX_W-1:0] idx);
    logic [31:0]     r;
    logic [SZ_W-1:0] sz;
    logic [1:0]      off;
    r = xorshift32();
    sz = 2'(r % 32'd3);
    off = (sz == SZ_BYTE) ? r[17:16] : (sz == SZ_HALF) ? {r[16], 1'b0} : 2'b00;
    exec_store(idx, {2'b10, r[15:4], off}, sz, xorshift32());
  endtask

  task automatic wait_idle();
    while (exp_idx.size() > 0 || exp_word.size() > 0 || due_q.size() > 0) step();
  endtask

  // cache model returns one credit per write after 1 to 6 cycles
  always @(posedge clk) begin
    #1;
    wr_credit = 1'b0;
    if (!rst && !hold_credits && due_q.size() > 0 && due_q[0] <= cycle) begin
      void'(due_q.pop_front());
      wr_credit = 1'b1;
    end
  end

  always @(negedge clk) begin
    logic [IDX_W-1:0] e_idx;
    logic             e_confl;
    if (!rst) begin
      if (ret_en) begin
        assert (exp_idx.size() > 0) else begin
          err_ret++;
          $display("slot %h retired with no retirement expected", ret_idx);
        end
        if (exp_idx.size() > 0) begin
          e_idx = exp_idx.pop_front();
          e_confl = exp_confl.pop_front();
          assert (ret_idx == e_idx) else begin
            err_ret++;
            $display("error ret_idx expected %h actual %h", e_idx, ret_idx);
          end
          assert (ret_confl == e_confl) else begin
            err_ret++;
            $display("error ret_confl expected %h actual %h", e_confl, ret_confl);
          end
          if (e_confl) begin
            // ring restarts just past the conflicting load
            tail_ref = e_idx + 3'd1;
            assert (alloc_idx == tail_ref) else begin
              err_ret++;
              $display("error alloc_idx expected %h actual %h", tail_ref, alloc_idx);
            end
          end
          if (exp_st.pop_front()) begin
            exp_word.push_back(slot_word[e_idx]);
            exp_ben.push_back(slot_ben[e_idx]);
            exp_data.push_back(slot_data[e_idx]);
          end
        end
      end
      if (wr_valid) begin
        due_q.push_back(cycle + 1 + int'(xorshift32() % 32'd6));
        assert (exp_word.size() > 0) else begin
          err_wr++;
          $display("cache write with no retired store pending");
        end
        if (exp_word.size() > 0) begin
          assert (wr_word == exp_word[0]) else begin
            err_wr++;
            $display("error wr_word expected %h actual %h", exp_word[0], wr_word);
          end
          assert (wr_ben == exp_ben[0]) else begin
            err_wr++;
            $display("error wr_ben expected %h actual %h", exp_ben[0], wr_ben);
          end
          assert (wr_data == exp_data[0]) else begin
            err_wr++;
            $display("error wr_data expected %h actual %h", exp_data[0], wr_data);
          end
          void'(exp_word.pop_front());
          void'(exp_ben.pop_front());
          void'(exp_data.pop_front());
        end
      end
      outstanding = outstanding + int'(wr_valid) - int'(wr_credit);
      assert (outstanding <= CACHE_CREDITS) else begin
        err_misc++;
        $display("more cache writes outstanding than credits: %0d", outstanding);
      end
    end
  end

  initial begin
    logic [IDX_W-1:0] slots [ROUND_OPS];
    logic             kinds [ROUND_OPS];
    int               order [ROUND_OPS];
    int               j;
    int               t;
    logic [IDX_W-1:0] s_i;
    logic [WORD_W-1:0] w;
    logic [31:0]      rv;
    logic             saw_full;
    repeat (5) @(posedge clk);
    #1;
    rst = 1'b0;
    @(negedge clk);
    assert (!ret_en) else begin
      err_misc++;
      $display("error ret_en expected 0 actual %h", ret_en);
    end
    assert (!wr_valid) else begin
      err_misc++;
      $display("error wr_valid expected 0 actual %h", wr_valid);
    end
    assert (!full) else begin
      err_misc++;
      $display("error full expected 0 actual %h", full);
    end
    assert (alloc_idx == '0) else begin
      err_misc++;
      $display("error alloc_idx expected 0 actual %h", alloc_idx);
    end
    step();

    // mixed rounds executed out of order with load and store words kept apart
    for (int r = 0; r < N_ROUNDS; r++) begin
      for (int i = 0; i < ROUND_OPS; i++) begin
        kinds[i] = xorshift32() % 32'd2 == 32'd1;
        slots[i] = tail_ref;
        alloc_op(kinds[i], 1'b0, 1'b1);
        order[i] = i;
      end
      for (int i = ROUND_OPS - 1; i > 0; i--) begin
        j = int'(xorshift32() % 32'(i + 1));
        t = order[i];
        order[i] = order[j];
        order[j] = t;
      end
      for (int i = 0; i < ROUND_OPS; i++) begin
        if (kinds[order[i]]) begin
          rand_store(slots[order[i]]);
        end else begin
          rv = xorshift32();
          exec_load(slots[order[i]], {2'b01, rv[13:0]});
        end
      end
      wait_idle();
    end

    // store, clean load, conflicting load, flushed load
    for (int c = 0; c < N_CONFL; c++) begin
      rv = xorshift32();
      w = {2'b11, rv[11:0]};
      s_i = tail_ref;
      alloc_op(1'b1, 1'b0, 1'b1);
      alloc_op(1'b0, 1'b0, 1'b1);
      alloc_op(1'b0, 1'b1, 1'b1);
      alloc_op(1'b0, 1'b0, 1'b0);
      exec_load(s_i + 3'd1, {w + 14'd2, 2'b00});
      exec_load(s_i + 3'd2, {w, 2'b01});
      exec_load(s_i + 3'd3, {w + 14'd1, 2'b00});
      exec_store(s_i, {w, 2'b00}, SZ_WORD, xorshift32());
      wait_idle();
    end

    // withheld credits back up the drain and fill the ring
    hold_credits = 1'b1;
    saw_full = 1'b0;
    for (int k = 0; k < BURST_MAX && !saw_full; k++) begin
      if (full) begin
        saw_full = 1'b1;
      end else begin
        s_i = tail_ref;
        alloc_op(1'b1, 1'b0, 1'b1);
        rand_store(s_i);
      end
    end
    assert (saw_full) else begin
      err_misc++;
      $display("full never rose while the cache withheld credits");
    end
    hold_credits = 1'b0;
    wait_idle();
    repeat (10) step();

    $display("errors: retire %0d, write %0d, other %0d", err_ret, err_wr, err_misc);
    if (err_ret + err_wr + err_misc == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* lsq_top.sv */
// load/store queue top level
`timescale 1ns/100ps
`default_nettype none

module lsq_top #(
  parameter int DEPTH         = 8,
  parameter int DRAIN_DEPTH   = 4,
  parameter int CACHE_CREDITS = 2,
  localparam int IDX_W = $clog2(DEPTH)
) (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        alloc_en,
  input  logic                        alloc_is_store,
  input  logic                        ld_en,
  input  logic [IDX_W-1:0]            ld_idx,
  input  lsq_pkg::lsq_addr_u          ld_addr,
  input  logic                        st_en,
  input  logic [IDX_W-1:0]            st_idx,
  input  lsq_pkg::lsq_addr_u          st_addr,
  input  logic [lsq_pkg::SZ_W-1:0]    st_size,
  input  logic [lsq_pkg::DATA_W-1:0]  st_data,
  input  logic                        wr_credit,
  output logic [IDX_W-1:0]            alloc_idx,
  output logic                        full,
  output logic                        ret_en,
  output logic [IDX_W-1:0]            ret_idx,
  output logic                        ret_confl,
  output logic                        wr_valid,
  output logic [lsq_pkg::WORD_W-1:0]  wr_word,
  output logic [lsq_pkg::BEN_W-1:0]   wr_ben,
  output logic [lsq_pkg::DATA_W-1:0]  wr_data
);
  import lsq_pkg::*;

  logic [IDX_W-1:0]  head_idx;
  logic [IDX_W-1:0]  tail_idx;
  logic              flush;
  logic              st_ret_en;
  logic [IDX_W-1:0]  st_ret_idx;
  logic [DEPTH-1:0]  ld_done;
  logic [DEPTH-1:0]  ld_confl;
  logic [DEPTH-1:0]  st_done;
  logic              drain_push;
  lsq_addr_u         drain_addr;
  logic [SZ_W-1:0]   drain_size;
  logic [DATA_W-1:0] drain_data;
  logic              drain_full;

  retire_decide #(.DEPTH(DEPTH)) retire_i (
    .clk(clk), .rst(rst),
    .alloc_en(alloc_en), .alloc_is_store(alloc_is_store),
    .ld_done(ld_done), .ld_confl(ld_confl), .st_done(st_done),
    .drain_full(drain_full),
    .alloc_idx(alloc_idx), .full(full),
    .head_idx(head_idx), .tail_idx(tail_idx), .flush(flush),
    .st_ret_en(st_ret_en), .st_ret_idx(st_ret_idx),
    .ret_en(ret_en), .ret_idx(ret_idx), .ret_confl(ret_confl)
  );

  load_queue #(.DEPTH(DEPTH)) ldq_i (
    .clk(clk), .rst(rst),
    .ld_en(ld_en), .ld_idx(ld_idx), .ld_addr(ld_addr),
    .st_en(st_en), .st_idx(st_idx), .st_addr(st_addr),
    .head_idx(head_idx), .tail_idx(tail_idx), .flush(flush),
    .ld_done(ld_done), .ld_confl(ld_confl)
  );

  store_queue #(.DEPTH(DEPTH)) stq_i (
    .clk(clk), .rst(rst),
    .st_en(st_en), .st_idx(st_idx), .st_addr(st_addr),
    .st_size(st_size), .st_data(st_data),
    .st_ret_en(st_ret_en), .st_ret_idx(st_ret_idx), .flush(flush),
    .st_done(st_done), .drain_push(drain_push),
    .drain_addr(drain_addr), .drain_size(drain_size), .drain_data(drain_data)
  );

  store_drain #(
    .DRAIN_DEPTH(DRAIN_DEPTH),
    .CACHE_CREDITS(CACHE_CREDITS)
  ) drain_i (
    .clk(clk), .rst(rst),
    .drain_push(drain_push), .drain_addr(drain_addr),
    .drain_size(drain_size), .drain_data(drain_data),
    .wr_credit(wr_credit), .drain_full(drain_full),
    .wr_valid(wr_valid), .wr_word(wr_word), .wr_ben(wr_ben), .wr_data(wr_data)
  );

endmodule

`default_nettype wire

/* retire_decide.sv */
// slot allocation and in-order retirement
`timescale 1ns/100ps
`default_nettype none

module retire_decide #(
  parameter int DEPTH = 8,
  localparam int IDX_W = $clog2(DEPTH)
) (
  input  logic             clk,
  input  logic             rst,
  input  logic             alloc_en,
  input  logic             alloc_is_store,
  input  logic [DEPTH-1:0] ld_done,
  input  logic [DEPTH-1:0] ld_confl,
  input  logic [DEPTH-1:0] st_done,
  input  logic             drain_full,
  output logic [IDX_W-1:0] alloc_idx,
  output logic             full,
  output logic [IDX_W-1:0] head_idx,
  output logic [IDX_W-1:0] tail_idx,
  output logic             flush,
  output logic             st_ret_en,
  output logic [IDX_W-1:0] st_ret_idx,
  output logic             ret_en,
  output logic [IDX_W-1:0] ret_idx,
  output logic             ret_confl
);

  logic [DEPTH-1:0] valid;
  logic [DEPTH-1:0] is_store;
  logic             head_store;
  logic             head_done;
  logic             retire;
  logic             alloc_ok;

  // status of the oldest slot from whichever queue owns it
  assign head_store = is_store[head_idx];
  assign head_done  = head_store ? st_done[head_idx] : ld_done[head_idx];
  assign retire     = valid[head_idx] && head_done && !(head_store && drain_full);

  assign flush      = retire && !head_store && ld_confl[head_idx];
  assign st_ret_en  = retire && head_store;
  assign st_ret_idx = head_idx;

  // no allocation while the ring is being flushed
  assign full      = (&valid) || flush;
  assign alloc_idx = tail_idx;
  assign alloc_ok  = alloc_en && !full;

  always_ff @(posedge clk) begin
    if (rst) begin
      valid    <= '0;
      head_idx <= '0;
      tail_idx <= '0;
      ret_en   <= 1'b0;
    end else begin
      ret_en <= retire;
      if (flush) begin
        // restart the ring just past the bad load
        valid    <= '0;
        head_idx <= head_idx + IDX_W'(1);
        tail_idx <= head_idx + IDX_W'(1);
      end else begin
        if (retire) begin
          valid[head_idx] <= 1'b0;
          head_idx        <= head_idx + IDX_W'(1);
        end
        if (alloc_ok) begin
          valid[tail_idx] <= 1'b1;
          tail_idx        <= tail_idx + IDX_W'(1);
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (alloc_ok) is_store[tail_idx] <= alloc_is_store;
    ret_idx   <= head_idx;
    ret_confl <= flush;
  end

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# compile and run the load/store queue testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f verilog.f --top-module lsq_tb -o lsq_sim > build.log 2>&1
if [ $? -ne 0 ]; then
  cat build.log
  echo "build failed"
  exit 1
fi

./obj_dir/lsq_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulator exited with status $status"
  exit 1
fi

if grep -q "Simulation failed" sim.log; then
  exit 1
fi
exit 0

/* store_drain.sv */
// store drain toward the cache
`timescale 1ns/100ps
`default_nettype none

module store_drain #(
  parameter int DRAIN_DEPTH   = 4,
  parameter int CACHE_CREDITS = 2
) (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        drain_push,
  input  lsq_pkg::lsq_addr_u          drain_addr,
  input  logic [lsq_pkg::SZ_W-1:0]    drain_size,
  input  logic [lsq_pkg::DATA_W-1:0]  drain_data,
  input  logic                        wr_credit,
  output logic                        drain_full,
  output logic                        wr_valid,
  output logic [lsq_pkg::WORD_W-1:0]  wr_word,
  output logic [lsq_pkg::BEN_W-1:0]   wr_ben,
  output logic [lsq_pkg::DATA_W-1:0]  wr_data
);
  import lsq_pkg::*;

  localparam int PTR_W = (DRAIN_DEPTH > 1) ? $clog2(DRAIN_DEPTH) : 1;
  localparam int CNT_W = $clog2(DRAIN_DEPTH + 1);
  localparam int CRD_W = $clog2(CACHE_CREDITS + 1);

  lsq_addr_u         fq_addr [DRAIN_DEPTH];
  logic [SZ_W-1:0]   fq_size [DRAIN_DEPTH];
  logic [DATA_W-1:0] fq_data [DRAIN_DEPTH];
  logic [PTR_W-1:0]  push_ptr;
  logic [PTR_W-1:0]  pop_ptr;
  logic [CNT_W-1:0]  count;
  logic [CRD_W-1:0]  credits;
  lsq_addr_u         pop_addr;
  logic [BEN_W-1:0]  size_mask;
  logic [DATA_W-1:0] size_data;

  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
    return (p == PTR_W'(DRAIN_DEPTH - 1)) ? '0 : p + PTR_W'(1);
  endfunction

  assign drain_full = (count == CNT_W'(DRAIN_DEPTH));
  // one write per held credit
  assign wr_valid   = (count != '0) && (credits != '0);
  assign pop_addr   = fq_addr[pop_ptr];

  always_comb begin
    case (fq_size[pop_ptr])
      SZ_BYTE: size_mask = BEN_W'(1);
      SZ_HALF: size_mask = BEN_W'(3);
      default: size_mask = '1;
    endcase
    for (int b = 0; b < BEN_W; b++) begin
      size_data[8*b +: 8] = size_mask[b] ? fq_data[pop_ptr][8*b +: 8] : 8'h00;
    end
  end

  // move bytes into their lanes
  assign wr_word = pop_addr.f.word;
  assign wr_ben  = size_mask << pop_addr.f.off;
  assign wr_data = size_data << {pop_addr.f.off, 3'b000};

  always_ff @(posedge clk) begin
    if (rst) begin
      push_ptr <= '0;
      pop_ptr  <= '0;
      count    <= '0;
      credits  <= CRD_W'(CACHE_CREDITS);
    end else begin
      if (drain_push) push_ptr <= ptr_inc(push_ptr);
      if (wr_valid) pop_ptr <= ptr_inc(pop_ptr);
      count   <= count + CNT_W'(drain_push) - CNT_W'(wr_valid);
      credits <= credits - CRD_W'(wr_valid) + CRD_W'(wr_credit);
    end
  end

  always_ff @(posedge clk) begin
    if (drain_push) begin
      fq_addr[push_ptr] <= drain_addr;
      fq_size[push_ptr] <= drain_size;
      fq_data[push_ptr] <= drain_data;
    end
  end

endmodule

`default_nettype wire

/* store_queue.sv */
// store queue slots
`timescale 1ns/100ps
`default_nettype none

module store_queue #(
  parameter int DEPTH = 8,
  localparam int IDX_W = $clog2(DEPTH)
) (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      st_en,
  input  logic [IDX_W-1:0]          st_idx,
  input  lsq_pkg::lsq_addr_u        st_addr,
  input  logic [lsq_pkg::SZ_W-1:0]  st_size,
  input  logic [lsq_pkg::DATA_W-1:0] st_data,
  input  logic                      st_ret_en,
  input  logic [IDX_W-1:0]          st_ret_idx,
  input  logic                      flush,
  output logic [DEPTH-1:0]          st_done,
  output logic                      drain_push,
  output lsq_pkg::lsq_addr_u        drain_addr,
  output logic [lsq_pkg::SZ_W-1:0]  drain_size,
  output logic [lsq_pkg::DATA_W-1:0] drain_data
);
  import lsq_pkg::*;

  lsq_addr_u         sq_addr [DEPTH];
  logic [SZ_W-1:0]   sq_size [DEPTH];
  logic [DATA_W-1:0] sq_data [DEPTH];
  logic [DEPTH-1:0]  done_set;
  logic [DEPTH-1:0]  done_clr;

  assign done_set = st_en ? (DEPTH'(1) << st_idx) : '0;
  assign done_clr = drain_push ? (DEPTH'(1) << st_ret_idx) : '0;

  // a retiring store goes straight to the drain FIFO
  assign drain_push = st_ret_en;

  // read port toward the drain FIFO
  assign drain_addr = sq_addr[st_ret_idx];
  assign drain_size = sq_size[st_ret_idx];
  assign drain_data = sq_data[st_ret_idx];

  always_ff @(posedge clk) begin
    if (rst) begin
      st_done <= '0;
    end else if (flush) begin
      st_done <= '0;
    end else begin
      st_done <= (st_done & ~done_clr) | done_set;
    end
  end

  // address, size and data of each store
  always_ff @(posedge clk) begin
    if (st_en) begin
      sq_addr[st_idx] <= st_addr;
      sq_size[st_idx] <= st_size;
      sq_data[st_idx] <= st_data;
    end
  end

endmodule

`default_nettype wire

/* verilog.f */
lsq_pkg.sv
load_queue.sv
store_queue.sv
store_drain.sv
retire_decide.sv
lsq_top.sv
lsq_tb.sv
